/* source/qsnd_pkg.sv */
/* qsound glue package
   register map, widths, bus structs and state encodings */
package qsnd_pkg;

    // widths and sizes
    localparam int addr_w        = 16;
    localparam int data_w        = 8;
    localparam int word_w        = 16;
    localparam int cmd_w         = 24;
    localparam int vol_w         = 13;
    localparam int vol_steps     = 40;
    localparam int vol_idx_w     = $clog2(vol_steps);
    localparam int sample_period = 1000;  // 48 kHz slots at 48 MHz
    localparam int slot_w        = $clog2(sample_period);

    localparam logic [slot_w-1:0]    slot_last = slot_w'(sample_period - 1);
    localparam logic [vol_idx_w-1:0] vol_last  = vol_idx_w'(vol_steps - 1);

    // host register map
    localparam logic [addr_w-1:0] reg_data_hi  = 16'hD000;
    localparam logic [addr_w-1:0] reg_data_lo  = 16'hD001;
    localparam logic [addr_w-1:0] reg_cmd_addr = 16'hD002;  // launches the command
    localparam logic [addr_w-1:0] reg_ctrl     = 16'hD003;
    localparam logic [addr_w-1:0] reg_status   = 16'hD007;

    localparam logic [data_w-1:0] idle_read = 8'hFF;

    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_write = 2'd1,
        op_read  = 2'd2
    } host_op_e;

    typedef enum logic [1:0] {
        mb_idle      = 2'd0,
        mb_send_addr = 2'd1,
        mb_send_data = 2'd2
    } mbox_state_e;

    // one host bus operation per cycle
    typedef struct packed {
        host_op_e          op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [cmd_w-word_w-1:0] addr;
        logic [word_w-1:0]       data;
    } dsp_cmd_t;

    // strobes coming back from the DSP
    typedef struct packed {
        logic              pids_n;
        logic              iack;
        logic              sadd;
        logic              psel;
        logic [word_w-1:0] serout;
    } dsp_port_t;

    typedef struct packed {
        logic signed [word_w-1:0] left;
        logic signed [word_w-1:0] right;
    } stereo_t;

endpackage

/* source/qsnd_host_regs.sv */
/* host register block
   latches the command word and control bits, answers status reads */
`timescale 1ns/1ps

module qsnd_host_regs (
    input  logic                            clk48,
    input  logic                            rst,
    input  qsnd_pkg::host_req_t             host_req,
    output logic [qsnd_pkg::data_w-1:0]     host_rdata,
    output qsnd_pkg::dsp_cmd_t              cmd,
    output logic                            cmd_load,
    input  logic                            irq_busy,
    input  logic                            dsp_iack,
    output logic                            dsp_rst
);

    logic       wr_en;
    logic       rd_en;
    logic       wr_data_hi;
    logic       wr_data_lo;
    logic       wr_cmd_addr;
    logic       wr_ctrl;
    logic       rd_status;
    logic       rdy_n;
    logic [3:0] bank;
    logic [qsnd_pkg::data_w-1:0] status_byte;

    assign wr_en = host_req.op == qsnd_pkg::op_write;
    assign rd_en = host_req.op == qsnd_pkg::op_read;

    // full address decode
    assign wr_data_hi  = wr_en && host_req.addr == qsnd_pkg::reg_data_hi;
    assign wr_data_lo  = wr_en && host_req.addr == qsnd_pkg::reg_data_lo;
    assign wr_cmd_addr = wr_en && host_req.addr == qsnd_pkg::reg_cmd_addr;
    assign wr_ctrl     = wr_en && host_req.addr == qsnd_pkg::reg_ctrl;
    assign rd_status   = host_req.addr == qsnd_pkg::reg_status;

    // DSP not ready while the interrupt or its acknowledge is up
    assign rdy_n       = ~(irq_busy | dsp_iack);
    assign status_byte = {rdy_n, 3'b111, bank};

    // command word, data bytes first then the address byte
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cmd      <= '0;
            cmd_load <= 1'b0;
        end else begin
            cmd_load <= wr_cmd_addr;  // lands together with the address byte
            if (wr_data_hi) begin
                cmd.data[15:8] <= host_req.wdata;
            end
            if (wr_data_lo) begin
                cmd.data[7:0] <= host_req.wdata;
            end
            if (wr_cmd_addr) begin
                cmd.addr <= host_req.wdata;
            end
        end
    end

    // bank select and DSP run bit
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1;  // DSP held until the CPU lets it run
        end else if (wr_ctrl) begin
            bank    <= host_req.wdata[3:0];
            dsp_rst <= ~host_req.wdata[7];
        end
    end

    // read data, kept until the next read
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            host_rdata <= qsnd_pkg::idle_read;
        end else if (rd_en) begin
            host_rdata <= rd_status ? status_byte : qsnd_pkg::idle_read;
        end
    end

endmodule

/* source/qsnd_mailbox.sv */
/* command mailbox
   feeds the latched command to the DSP parallel input, address then data */
`timescale 1ns/1ps

module qsnd_mailbox (
    input  logic                            clk48,
    input  logic                            rst,
    input  qsnd_pkg::dsp_cmd_t              cmd,
    input  logic                            cmd_load,
    input  logic                            pids_n,
    output logic                            dsp_irq,
    output logic                            irq_busy,
    output logic [qsnd_pkg::word_w-1:0]     dsp_pbus_in
);

    qsnd_pkg::mbox_state_e state;
    qsnd_pkg::dsp_cmd_t    held;
    logic                  last_pids_n;
    logic                  pids_rise;

    assign pids_rise = pids_n & ~last_pids_n;  // DSP done reading the bus

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= pids_n;
        end
    end

    // copy of the word in flight
    always_ff @(posedge clk48) begin
        if (cmd_load) begin
            held <= cmd;
        end
    end

    // a new command always restarts the sequence
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            state   <= qsnd_pkg::mb_idle;
            dsp_irq <= 1'b0;
        end else if (cmd_load) begin
            state   <= qsnd_pkg::mb_send_addr;
            dsp_irq <= 1'b1;
        end else if (pids_rise) begin
            case (state)
                qsnd_pkg::mb_send_addr: begin
                    state   <= qsnd_pkg::mb_send_data;
                    dsp_irq <= 1'b0;
                end
                qsnd_pkg::mb_send_data: begin
                    state <= qsnd_pkg::mb_idle;
                end
                default: begin
                    state <= qsnd_pkg::mb_idle;  // stray strobe
                end
            endcase
        end
    end

    assign irq_busy = dsp_irq;

    // address byte zero extended, data word otherwise
    assign dsp_pbus_in = (state == qsnd_pkg::mb_send_addr) ?
                         {8'd0, held.addr} : held.data;

endmodule

/* source/qsnd_sample_out.sv */
/* sample output stage
   captures DSP serial words, gates the DSP clock enable, paces stereo output */
`timescale 1ns/1ps

module qsnd_sample_out (
    input  logic                            clk48,
    input  logic                            rst,
    input  logic                            sadd,
    input  logic                            psel,
    input  logic [qsnd_pkg::word_w-1:0]     serout,
    output logic                            dsp_cen,
    output qsnd_pkg::stereo_t               audio,
    output logic                            sample
);

    logic                        last_sadd;
    logic                        last_psel;
    logic                        sadd_fall;
    logic                        psel_rise;
    logic                        slot_wrap;
    logic [qsnd_pkg::slot_w-1:0] slot_cnt;
    qsnd_pkg::stereo_t           partial;   // pair being filled
    qsnd_pkg::stereo_t           pending;   // last completed pair

    assign sadd_fall = ~sadd & last_sadd;
    assign psel_rise = psel & ~last_psel;
    assign slot_wrap = slot_cnt == qsnd_pkg::slot_last;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_sadd <= 1'b0;
            last_psel <= 1'b0;
        end else begin
            last_sadd <= sadd;
            last_psel <= psel;
        end
    end

    // psel low selects left, high selects right
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            partial <= '0;
            pending <= '0;
        end else begin
            if (sadd_fall) begin
                if (!psel) begin
                    partial.left <= serout;
                end else begin
                    partial.right <= serout;
                end
            end
            if (psel_rise) begin
                pending <= partial;
            end
        end
    end

    // free running sample slot counter
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (slot_wrap) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // DSP sleeps from a finished pair to the next slot
    // the slot wrap wins over a psel edge in the same cycle
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            dsp_cen <= 1'b1;
            audio   <= '0;
            sample  <= 1'b0;
        end else begin
            sample <= slot_wrap;
            if (slot_wrap) begin
                dsp_cen <= 1'b1;
                audio   <= pending;
            end else if (psel_rise) begin
                dsp_cen <= 1'b0;
            end
        end
    end

endmodule

/* source/qsnd_volume.sv */
/* volume stepper
   up/down buttons walk a 40 step attenuation table */
`timescale 1ns/1ps

module qsnd_volume (
    input  logic                            clk48,
    input  logic                            rst,
    input  logic                            vol_up,
    input  logic                            vol_down,
    output logic [qsnd_pkg::vol_w-1:0]      volume
);

    logic [qsnd_pkg::vol_idx_w-1:0] step;
    logic                           last_up;
    logic                           last_down;
    logic                           up_rise;
    logic                           down_rise;
    logic [qsnd_pkg::vol_w-1:0]     vol_lut [qsnd_pkg::vol_steps];

    // coarse bit drops every 5 steps, fine bit walks within them
    function automatic logic [qsnd_pkg::vol_w-1:0] vol_entry(
        input logic [qsnd_pkg::vol_idx_w-1:0] idx
    );
        return (13'h1000 >> (idx / 5)) | (13'h0010 >> (idx % 5));
    endfunction

    always_comb begin
        for (int i = 0; i < qsnd_pkg::vol_steps; i++) begin
            vol_lut[i] = vol_entry(qsnd_pkg::vol_idx_w'(i));
        end
    end

    assign up_rise   = vol_up & ~last_up;
    assign down_rise = vol_down & ~last_down;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_up   <= 1'b0;
            last_down <= 1'b0;
            step      <= '0;
            volume    <= vol_entry('0);
        end else begin
            last_up   <= vol_up;
            last_down <= vol_down;
            if (up_rise) begin  // up has priority
                if (step != qsnd_pkg::vol_last) begin
                    step <= step + 1'b1;
                end
            end else if (down_rise) begin
                if (step != '0) begin
                    step <= step - 1'b1;
                end
            end
            volume <= vol_lut[step];
        end
    end

endmodule

/* source/qsnd_sound.sv */
/* qsound audio glue top
   host registers, DSP command mailbox, sample output and volume control */
`timescale 1ns/1ps

module qsnd_sound (
    input  logic                            clk48,
    input  logic                            rst,
    // sound CPU
    input  qsnd_pkg::host_req_t             host_req,
    output logic [qsnd_pkg::data_w-1:0]     host_rdata,
    // DSP side
    input  qsnd_pkg::dsp_port_t             dsp_port,
    output logic [qsnd_pkg::word_w-1:0]     dsp_pbus_in,
    output logic                            dsp_irq,
    output logic                            dsp_rst,
    output logic                            dsp_cen,
    // volume buttons
    input  logic                            vol_up,
    input  logic                            vol_down,
    output logic [qsnd_pkg::vol_w-1:0]      volume,
    // audio out
    output qsnd_pkg::stereo_t               audio,
    output logic                            sample
);

    qsnd_pkg::dsp_cmd_t cmd;
    logic               cmd_load;
    logic               irq_busy;

    qsnd_host_regs u_regs (
        .clk48      ( clk48           ),
        .rst        ( rst             ),
        .host_req   ( host_req        ),
        .host_rdata ( host_rdata      ),
        .cmd        ( cmd             ),
        .cmd_load   ( cmd_load        ),
        .irq_busy   ( irq_busy        ),
        .dsp_iack   ( dsp_port.iack   ),
        .dsp_rst    ( dsp_rst         )
    );

    qsnd_mailbox u_mbox (
        .clk48       ( clk48           ),
        .rst         ( rst             ),
        .cmd         ( cmd             ),
        .cmd_load    ( cmd_load        ),
        .pids_n      ( dsp_port.pids_n ),
        .dsp_irq     ( dsp_irq         ),
        .irq_busy    ( irq_busy        ),
        .dsp_pbus_in ( dsp_pbus_in     )
    );

    qsnd_sample_out u_out (
        .clk48   ( clk48           ),
        .rst     ( rst             ),
        .sadd    ( dsp_port.sadd   ),
        .psel    ( dsp_port.psel   ),
        .serout  ( dsp_port.serout ),
        .dsp_cen ( dsp_cen         ),
        .audio   ( audio           ),
        .sample  ( sample          )
    );

    qsnd_volume u_vol (
        .clk48    ( clk48    ),
        .rst      ( rst      ),
        .vol_up   ( vol_up   ),
        .vol_down ( vol_down ),
        .volume   ( volume   )
    );

endmodule

/* dv/qsnd_properties.sv */
/* control signal assertions for the qsound glue top
   bound onto qsnd_sound */
`timescale 1ns/1ps

module qsnd_properties (
    input logic clk48,
    input logic rst,
    input logic sample,
    input logic dsp_irq,
    input logic dsp_cen
);

    // strobe is a single cycle
    sample_one_cycle: assert property (
        @(posedge clk48) disable iff (rst) sample |=> !sample
    ) else $error("sample strobe held for two cycles");

    irq_low_after_reset: assert property (
        @(posedge clk48) $fell(rst) |-> !dsp_irq
    ) else $error("dsp_irq high right after reset");

    // DSP is running again when a slot starts
    cen_high_on_sample: assert property (
        @(posedge clk48) disable iff (rst) sample |-> dsp_cen
    ) else $error("dsp_cen low during sample strobe");

endmodule

bind qsnd_sound qsnd_properties u_props (
    .clk48   ( clk48   ),
    .rst     ( rst     ),
    .sample  ( sample  ),
    .dsp_irq ( dsp_irq ),
    .dsp_cen ( dsp_cen )
);

/* dv/qsnd_tb.sv */
/* qsound glue testbench
   random host, DSP and button traffic checked cycle by cycle against a model */
`timescale 1ns/1ps

module qsnd_tb;

    localparam int n_trans   = 40;
    localparam int trans_len = 200;  // cycles per transaction
    localparam int clk_ns    = 4;

    logic                clk48;
    logic                rst;
    qsnd_pkg::host_req_t host_req;
    logic [7:0]          host_rdata;
    qsnd_pkg::dsp_port_t dsp_port;
    logic [15:0]         dsp_pbus_in;
    logic                dsp_irq;
    logic                dsp_rst;
    logic                dsp_cen;
    logic                vol_up;
    logic                vol_down;
    logic [12:0]         volume;
    qsnd_pkg::stereo_t   audio;
    logic                sample;

    integer seed;
    int     cyc;
    int     last_sample;

    // reference model state
    logic [15:0]           m_data;
    logic [7:0]            m_addr;
    logic [15:0]           h_data;
    logic [7:0]            h_addr;
    logic                  h_valid;
    logic                  m_load;
    qsnd_pkg::mbox_state_e m_state;
    logic                  m_irq;
    logic [3:0]            m_bank;
    logic                  m_rst_dsp;
    logic [7:0]            m_rdata;
    logic                  prev_pids;
    logic                  prev_sadd;
    logic                  prev_psel;
    logic                  prev_up;
    logic                  prev_down;
    qsnd_pkg::stereo_t     m_partial;
    qsnd_pkg::stereo_t     m_pending;
    qsnd_pkg::stereo_t     m_audio;
    logic                  m_cen;
    logic                  m_sample;
    int                    m_slot;
    int                    m_step;
    logic [12:0]           m_vol;

    qsnd_sound dut_i (
        .clk48       ( clk48       ),
        .rst         ( rst         ),
        .host_req    ( host_req    ),
        .host_rdata  ( host_rdata  ),
        .dsp_port    ( dsp_port    ),
        .dsp_pbus_in ( dsp_pbus_in ),
        .dsp_irq     ( dsp_irq     ),
        .dsp_rst     ( dsp_rst     ),
        .dsp_cen     ( dsp_cen     ),
        .vol_up      ( vol_up      ),
        .vol_down    ( vol_down    ),
        .volume      ( volume      ),
        .audio       ( audio       ),
        .sample      ( sample      )
    );

    initial begin
        clk48 = 1'b0;
        forever #(clk_ns / 2) clk48 = ~clk48;
    end

    // major step halves the coarse bit, minor step halves the fine bit
    function automatic logic [12:0] vol_rule(input int i);
        return (13'h1000 >> (i / 5)) | (13'h0010 >> (i % 5));
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_reset_state();
        compare("dsp_irq", 32'(1'b0), 32'(dsp_irq));
        compare("sample", 32'(1'b0), 32'(sample));
        compare("dsp_rst", 32'(1'b1), 32'(dsp_rst));
        compare("dsp_cen", 32'(1'b1), 32'(dsp_cen));
        compare("volume", 32'(vol_rule(0)), 32'(volume));
        compare("audio", 32'(0), audio);
        compare("host_rdata", 32'(8'hFF), 32'(host_rdata));
    endtask

    // one random cycle on every input 1 ns after the edge
    task automatic drive_cycle(input logic climb);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        @(posedge clk48);
        #1;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        host_req.op    = (r1[2:0] == 3'd0) ? qsnd_pkg::op_write :
                         (r1[2:0] == 3'd1) ? qsnd_pkg::op_read : qsnd_pkg::op_idle;
        host_req.addr  = r1[5] ? (16'hD000 | {13'd0, r1[8:6]}) : r1[31:16];  // mostly the map
        host_req.wdata = r3[7:0];
        dsp_port.sadd   = r2[0];
        dsp_port.serout = r2[31:16];
        dsp_port.iack   = r2[11:9] == 3'd0;
        if (r2[5:1] == 5'd0) begin
            dsp_port.psel = ~dsp_port.psel;  // roughly one pair per 64 cycles
        end
        if (r2[8:6] == 3'd0) begin
            dsp_port.pids_n = ~dsp_port.pids_n;
        end
        if (r3[11:8] == 4'd0) begin
            vol_up = ~vol_up;
        end
        // fewer down presses while climbing so the step reaches the top
        if (climb ? (r3[15:10] == 6'd0) : (r3[15:12] == 4'd0)) begin
            vol_down = ~vol_down;
        end
    endtask

    // reference model on the same edges as the DUT
    always @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cyc       = 0;
            m_data    = '0;
            m_addr    = '0;
            m_load    = 1'b0;
            m_state   = qsnd_pkg::mb_idle;
            m_irq     = 1'b0;
            m_bank    = '0;
            m_rst_dsp = 1'b1;
            m_rdata   = 8'hFF;
            prev_pids = 1'b1;
            prev_sadd = 1'b0;
            prev_psel = 1'b0;
            prev_up   = 1'b0;
            prev_down = 1'b0;
            m_partial = '0;
            m_pending = '0;
            m_audio   = '0;
            m_cen     = 1'b1;
            m_sample  = 1'b0;
            m_slot    = 0;
            m_step    = 0;
            m_vol     = vol_rule(0);
        end else begin
            cyc = cyc + 1;
            if (host_req.op == qsnd_pkg::op_read) begin  // status sees the old irq
                m_rdata = (host_req.addr == 16'hD007) ?
                          {~(m_irq | dsp_port.iack), 3'b111, m_bank} : 8'hFF;
            end
            if (m_load) begin
                m_state = qsnd_pkg::mb_send_addr;
                m_irq   = 1'b1;
                h_data  = m_data;
                h_addr  = m_addr;
                h_valid = 1'b1;
            end else if (dsp_port.pids_n && !prev_pids) begin
                if (m_state == qsnd_pkg::mb_send_addr) begin
                    m_state = qsnd_pkg::mb_send_data;
                    m_irq   = 1'b0;
                end else begin
                    m_state = qsnd_pkg::mb_idle;
                end
            end
            prev_pids = dsp_port.pids_n;
            m_load    = 1'b0;
            if (host_req.op == qsnd_pkg::op_write) begin
                case (host_req.addr)
                    16'hD000: m_data[15:8] = host_req.wdata;
                    16'hD001: m_data[7:0] = host_req.wdata;
                    16'hD002: begin
                        m_addr = host_req.wdata;
                        m_load = 1'b1;
                    end
                    16'hD003: begin
                        m_bank    = host_req.wdata[3:0];
                        m_rst_dsp = ~host_req.wdata[7];
                    end
                    default: ;
                endcase
            end
            m_sample = m_slot == qsnd_pkg::sample_period - 1;
            if (m_sample) begin
                m_audio = m_pending;
                m_cen   = 1'b1;
            end else if (dsp_port.psel && !prev_psel) begin
                m_cen = 1'b0;
            end
            if (dsp_port.psel && !prev_psel) begin
                m_pending = m_partial;  // pair as it stood before this edge
            end
            if (!dsp_port.sadd && prev_sadd) begin
                if (!dsp_port.psel) begin
                    m_partial.left = dsp_port.serout;
                end else begin
                    m_partial.right = dsp_port.serout;
                end
            end
            m_slot    = m_sample ? 0 : m_slot + 1;
            prev_sadd = dsp_port.sadd;
            prev_psel = dsp_port.psel;
            m_vol     = vol_rule(m_step);
            if (vol_up && !prev_up) begin
                m_step = (m_step < qsnd_pkg::vol_steps - 1) ? m_step + 1 : m_step;
            end else if (vol_down && !prev_down) begin
                m_step = (m_step > 0) ? m_step - 1 : m_step;
            end
            prev_up   = vol_up;
            prev_down = vol_down;
        end
    end

    // outputs compared on the falling edge
    always @(negedge clk48) begin
        if (rst) begin
            last_sample = -1;
        end else begin
            compare("dsp_irq", 32'(m_irq), 32'(dsp_irq));
            compare("dsp_rst", 32'(m_rst_dsp), 32'(dsp_rst));
            compare("dsp_cen", 32'(m_cen), 32'(dsp_cen));
            compare("sample", 32'(m_sample), 32'(sample));
            compare("audio", m_audio, audio);
            compare("volume", 32'(m_vol), 32'(volume));
            compare("host_rdata", 32'(m_rdata), 32'(host_rdata));
            if (h_valid) begin
                compare("dsp_pbus_in",
                        (m_state == qsnd_pkg::mb_send_addr) ? {24'd0, h_addr} : {16'd0, h_data},
                        32'(dsp_pbus_in));
            end
            if (sample) begin
                if (last_sample >= 0) begin
                    compare("sample_spacing", 32'(qsnd_pkg::sample_period),
                            32'(cyc - last_sample));
                end
                last_sample = cyc;
            end
        end
    end

    initial begin
        #(n_trans * 2 * qsnd_pkg::sample_period * clk_ns);
        $display("watchdog expired before the stimulus finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed            = 75;
        h_valid         = 1'b0;
        h_data          = '0;
        h_addr          = '0;
        last_sample     = -1;
        rst             = 1'b1;
        host_req        = '0;
        dsp_port        = '0;
        dsp_port.pids_n = 1'b1;
        vol_up          = 1'b0;
        vol_down        = 1'b0;
        repeat (10) @(posedge clk48);
        #1 rst = 1'b0;
        check_reset_state();
        for (int t = 0; t < n_trans; t++) begin
            if (t == n_trans / 2) begin  // mid-run reset
                @(posedge clk48);
                #1 rst = 1'b1;
                repeat (10) @(posedge clk48);
                #1 rst = 1'b0;
                check_reset_state();
            end
            repeat (trans_len) drive_cycle(t < n_trans / 2);
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* qsnd.f */
source/qsnd_pkg.sv
source/qsnd_host_regs.sv
source/qsnd_mailbox.sv
source/qsnd_sample_out.sv
source/qsnd_volume.sv
source/qsnd_sound.sv
dv/qsnd_properties.sv
dv/qsnd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the qsound glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f qsnd.f --top-module qsnd_tb -o qsnd_sim \
    && ./obj_dir/qsnd_sim | grep "^Test passed$" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
